// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mask_mem
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hw/mask_mem_top.sv
// Top level joining the Wishbone port, the control registers and the masked-write memory
`timescale 1ns/1ns

module mask_mem_top #(
  parameter int ELS = 64
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               cyc_i,
  input  logic               stb_i,
  input  logic               we_i,
  input  logic [AW:0]        adr_i,
  input  maskmem_pkg::word_t dat_i,
  input  maskmem_pkg::sel_t  sel_i,
  output logic               ack_o,
  output maskmem_pkg::word_t dat_o
);

  localparam int AW = (ELS > 1) ? $clog2(ELS) : 1;

  maskmem_pkg::mem_req_t  mem_req;
  logic [AW-1:0]          mem_addr;
  maskmem_pkg::word_t     mem_data;
  maskmem_pkg::mem_req_t  reg_req;
  maskmem_pkg::reg_addr_t reg_addr;
  maskmem_pkg::word_t     reg_data;
  maskmem_pkg::word_t     wmask;
  // Bypass pulses toward the counter
  logic                   hazard;

  wb_mem_port #(.ELS(ELS)) i_port (
    .clk_i(clk_i), .rst_i(rst_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
    .adr_i(adr_i), .dat_i(dat_i), .sel_i(sel_i), .ack_o(ack_o), .dat_o(dat_o),
    .mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_data_i(mem_data),
    .reg_req_o(reg_req), .reg_addr_o(reg_addr), .wmask_i(wmask), .reg_data_i(reg_data)
  );

  mem_ctrl_regs i_regs (
    .clk_i(clk_i), .rst_i(rst_i), .reg_req_i(reg_req), .reg_addr_i(reg_addr),
    .hazard_i(hazard), .wmask_o(wmask), .reg_data_o(reg_data)
  );

  mask_write_mem #(.ELS(ELS)) i_mem (
    .clk_i(clk_i), .rst_i(rst_i), .req_i(mem_req), .addr_i(mem_addr),
    .data_o(mem_data), .hazard_o(hazard)
  );

endmodule

// File: hw/mask_write_mem.sv
// Bit-masked single-port memory on a 1R1W RAM, with read-modify-write, bypass and write merging
`timescale 1ns/1ns

module mask_write_mem #(
  parameter int ELS = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  maskmem_pkg::mem_req_t req_i,
  input  logic [AW-1:0]         addr_i,
  output maskmem_pkg::word_t    data_o,
  output logic                  hazard_o
);

  localparam int AW = (ELS > 1) ? $clog2(ELS) : 1;

  // Write request in this cycle
  logic               wr_n;
  // Write request in the previous cycle, RAM write pending now
  logic               wr_r;
  // Address of the previous access
  logic [AW-1:0]      w_addr_r;
  // Mask of the previous write
  maskmem_pkg::word_t w_mask_r;
  logic               addr_match;
  // Bypass taken this cycle and last cycle
  logic               bypass_n;
  logic               bypass_r;
  // Latest running value of the pending word, or new write data
  maskmem_pkg::word_t byp_data_r;
  // Old word from the RAM
  maskmem_pkg::word_t ram_rd;
  // Word to write back this cycle
  maskmem_pkg::word_t merged;
  logic               ram_re;
  logic               ram_we;

  assign wr_n       = req_i.valid & req_i.we;
  assign addr_match = (w_addr_r == addr_i);

  // Same-address access right after a write
  assign bypass_n = req_i.valid & wr_r & addr_match;
  assign hazard_o = bypass_n;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      wr_r     <= 1'b0;
      bypass_r <= 1'b0;
    end
    else
    begin
      wr_r     <= wr_n;
      bypass_r <= bypass_n;
    end
  end

  // Address of every access, compared next cycle
  always_ff @(posedge clk_i)
  begin
    if (req_i.valid)
      w_addr_r <= addr_i;
  end

  // Mask kept only for writes
  always_ff @(posedge clk_i)
  begin
    if (wr_n)
      w_mask_r <= req_i.mask;
  end

  // After a bypass the buffer already holds the full word
  // Otherwise merge new bits over the RAM word
  assign merged = bypass_r ? byp_data_r
                           : (ram_rd & ~w_mask_r) | (byp_data_r & w_mask_r);

  always_ff @(posedge clk_i)
  begin
    if (bypass_n && req_i.we)
      // Two writes in a row fold into one word
      byp_data_r <= (merged & ~req_i.mask) | (req_i.data & req_i.mask);
    else if (bypass_n)
      // Read of the pending word
      byp_data_r <= merged;
    else
      byp_data_r <= req_i.data;
  end

  // Skip the RAM read when the buffer serves it
  assign ram_re = req_i.valid & ~bypass_n;

  // Skip the pending write when the next write to that word absorbs it
  assign ram_we = wr_r & ~(wr_n & addr_match);

  ram_1r1w_sync #(
    .ELS (ELS)
  ) i_ram (
    .clk_i    (clk_i),
    .w_v_i    (ram_we),
    .w_addr_i (w_addr_r),
    .w_data_i (merged),
    .r_v_i    (ram_re),
    .r_addr_i (addr_i),
    .r_data_o (ram_rd)
  );

  assign data_o = bypass_r ? byp_data_r : ram_rd;

  // A word written back is what the RAM returns for that address one cycle later
  a_write_visible: assert property (@(posedge clk_i) disable iff (rst_i)
    (ram_re && $past(ram_we) && (addr_i == $past(w_addr_r)))
    |=> (ram_rd == $past(merged, 2)));

endmodule

// File: hw/maskmem_pkg.sv
// Shared word, select and request types plus register offsets for the masked-write memory
package maskmem_pkg;

  // Data word width, one mask bit per data bit
  localparam int WORD_W = 32;

  // One byte select per byte of a word
  localparam int SEL_W = WORD_W / 8;

  // Register space holds two registers
  localparam int REG_AW = 1;

  // Memory and bus data word, also used as a bit mask
  typedef logic [WORD_W-1:0] word_t;

  // Wishbone byte selects
  typedef logic [SEL_W-1:0] sel_t;

  // Offset inside the register space
  typedef logic [REG_AW-1:0] reg_addr_t;

  // One request toward the memory or the register block
  // Address travels beside it since its width follows ELS
  typedef struct packed {
    logic  valid;
    logic  we;
    word_t data;
    // 1 takes the new bit, 0 keeps the stored one
    word_t mask;
  } mem_req_t;

  // Write mask register, read and write
  localparam reg_addr_t REG_MASK = reg_addr_t'(0);

  // Bypass event counter, read only
  localparam reg_addr_t REG_HAZARDS = reg_addr_t'(1);

endpackage

// File: hw/mem_ctrl_regs.sv
// Control registers holding the bit write mask and a saturating bypass event counter
`timescale 1ns/1ns

module mem_ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  maskmem_pkg::mem_req_t  reg_req_i,
  input  maskmem_pkg::reg_addr_t reg_addr_i,
  input  logic                   hazard_i,
  output maskmem_pkg::word_t     wmask_o,
  output maskmem_pkg::word_t     reg_data_o
);

  // Write mask, all bits writable after reset
  maskmem_pkg::word_t wmask_r;
  // Bypass events seen by the memory
  maskmem_pkg::word_t hazard_cnt;
  logic               mask_wr;

  assign mask_wr = reg_req_i.valid & reg_req_i.we
                 & (reg_addr_i == maskmem_pkg::REG_MASK);

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      wmask_r <= '1;
    else if (mask_wr)
      wmask_r <= reg_req_i.data;
  end

  // Counter sticks at its top value
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      hazard_cnt <= '0;
    else if (hazard_i && (hazard_cnt != '1))
      hazard_cnt <= hazard_cnt + 1'b1;
  end

  // Registered read mux, value returns with ack
  always_ff @(posedge clk_i)
  begin
    if (reg_req_i.valid)
    begin
      if (reg_addr_i == maskmem_pkg::REG_HAZARDS)
        reg_data_o <= hazard_cnt;
      else
        reg_data_o <= wmask_r;
    end
  end

  assign wmask_o = wmask_r;

endmodule

// File: hw/ram_1r1w_sync.sv
// Behavioral synchronous RAM with one write port and one registered read port
`timescale 1ns/1ns

module ram_1r1w_sync #(
  parameter int ELS = 64
) (
  input  logic                     clk_i,
  input  logic                     w_v_i,
  input  logic [AW-1:0]            w_addr_i,
  input  maskmem_pkg::word_t       w_data_i,
  input  logic                     r_v_i,
  input  logic [AW-1:0]            r_addr_i,
  output maskmem_pkg::word_t       r_data_o
);

  localparam int AW = (ELS > 1) ? $clog2(ELS) : 1;

  // Storage, no reset on contents
  maskmem_pkg::word_t mem [ELS];

  // Write at the clock edge
  always_ff @(posedge clk_i)
  begin
    if (w_v_i)
      mem[w_addr_i] <= w_data_i;
  end

  // Read data registered, held when no read is made
  always_ff @(posedge clk_i)
  begin
    if (r_v_i)
      r_data_o <= mem[r_addr_i];
  end

  // Both ports stay inside the array
  a_addr_range: assert property (@(posedge clk_i)
    (w_v_i |-> (int'(w_addr_i) < ELS)) and (r_v_i |-> (int'(r_addr_i) < ELS)));

endmodule

// File: hw/wb_mem_port.sv
// Wishbone pipelined slave that splits requests between memory and registers and returns ack
`timescale 1ns/1ns

module wb_mem_port #(
  parameter int ELS = 64
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  input  logic                   we_i,
  input  logic [AW:0]            adr_i,
  input  maskmem_pkg::word_t     dat_i,
  input  maskmem_pkg::sel_t      sel_i,
  output logic                   ack_o,
  output maskmem_pkg::word_t     dat_o,
  output maskmem_pkg::mem_req_t  mem_req_o,
  output logic [AW-1:0]          mem_addr_o,
  input  maskmem_pkg::word_t     mem_data_i,
  output maskmem_pkg::mem_req_t  reg_req_o,
  output maskmem_pkg::reg_addr_t reg_addr_o,
  input  maskmem_pkg::word_t     wmask_i,
  input  maskmem_pkg::word_t     reg_data_i
);

  localparam int AW = (ELS > 1) ? $clog2(ELS) : 1;

  // Request accepted this cycle, no stall
  logic               acc;
  // Top address bit picks the register space
  logic               reg_space;
  // Byte selects spread to one bit per data bit
  maskmem_pkg::word_t sel_bits;
  logic               ack_r;
  // Space of the request being acked
  logic               reg_space_r;

  assign acc       = cyc_i & stb_i;
  assign reg_space = adr_i[AW];

  always_comb
  begin
    for (int i = 0; i < maskmem_pkg::SEL_W; i++)
      sel_bits[8*i +: 8] = {8{sel_i[i]}};
  end

  // Memory request, reads carry no mask
  assign mem_req_o.valid = acc & ~reg_space;
  assign mem_req_o.we    = we_i;
  assign mem_req_o.data  = dat_i;
  assign mem_req_o.mask  = we_i ? (wmask_i & sel_bits) : '0;
  assign mem_addr_o      = adr_i[AW-1:0];

  // Register request, whole-word writes
  assign reg_req_o.valid = acc & reg_space;
  assign reg_req_o.we    = we_i;
  assign reg_req_o.data  = dat_i;
  assign reg_req_o.mask  = '0;
  assign reg_addr_o      = adr_i[maskmem_pkg::REG_AW-1:0];

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      ack_r <= 1'b0;
    else
      ack_r <= acc;
  end

  always_ff @(posedge clk_i)
  begin
    reg_space_r <= reg_space;
  end

  assign ack_o = ack_r;
  assign dat_o = reg_space_r ? reg_data_i : mem_data_i;

  // Strobe only inside a bus cycle, a lone strobe would never be acked
  a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    stb_i |-> cyc_i);

endmodule

// File: sim/tb_mask_mem.sv
// Testbench for the masked-write memory with a reference model, Wishbone stimulus and checks
`timescale 1ns/1ns

module tb_mask_mem;

  logic                  clk_i;
  logic                  rst_i;
  logic                  cyc_i;
  logic                  stb_i;
  logic                  we_i;
  logic [6:0]            adr_i;
  maskmem_pkg::word_t    dat_i;
  maskmem_pkg::sel_t     sel_i;
  logic                  ack_o;
  maskmem_pkg::word_t    dat_o;

  // Reference model state
  maskmem_pkg::word_t    ref_mem [64];
  maskmem_pkg::word_t    ref_mask;
  logic [31:0]           ref_haz;
  // Previous cycle was a memory write, and its address
  logic                  prev_wr;
  logic [5:0]            prev_addr;
  // Expected ack data, top bit set when dat_o is checked
  logic [32:0]           exp_q [$];
  logic [32:0]           exp_front;
  int                    errors;
  int                    checks;
  int                    err_start;

  mask_mem_top #(.ELS(64)) i_dut (
    .clk_i(clk_i), .rst_i(rst_i), .cyc_i(cyc_i), .stb_i(stb_i), .we_i(we_i),
    .adr_i(adr_i), .dat_i(dat_i), .sel_i(sel_i), .ack_o(ack_o), .dat_o(dat_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Ack exactly one cycle after each accepted request
  a_ack_timing: assert property (@(posedge clk_i) disable iff (rst_i)
    ack_o == $past(cyc_i && stb_i))
    else
    begin
      errors = errors + 1;
      $display("ERROR at %0t: ack_o does not follow an accepted request by one cycle", $time);
    end

  // Outputs settle well before the falling edge
  always @(negedge clk_i)
  begin
    if (!rst_i && ack_o)
    begin
      if (exp_q.size() == 0)
      begin
        errors = errors + 1;
        $display("ERROR at %0t: ack_o seen with no request outstanding", $time);
      end
      else
      begin
        exp_front = exp_q.pop_front();
        if (exp_front[32])
        begin
          checks = checks + 1;
          assert (dat_o === exp_front[31:0])
          else
          begin
            errors = errors + 1;
            $display("MISMATCH at %0t: dat_o expected %h got %h",
                     $time, exp_front[31:0], dat_o);
          end
        end
      end
    end
  end

  // One mask bit per data bit from the byte selects
  function automatic maskmem_pkg::word_t expand_sel(input maskmem_pkg::sel_t s);
    return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
  endfunction

  // One bus request, model updated in request order
  task automatic access(input logic we, input logic reg_sp, input logic [5:0] a,
                        input maskmem_pkg::word_t d, input maskmem_pkg::sel_t s);
    maskmem_pkg::word_t m;
    m = ref_mask & expand_sel(s);
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = we;
    adr_i = {reg_sp, a};
    dat_i = d;
    sel_i = s;
    if (reg_sp)
    begin
      // Offset 0 is the mask, offset 1 the read-only counter
      if (we && !a[0])
        ref_mask = d;
      exp_q.push_back({~we, (a[0] ? ref_haz : ref_mask)});
      prev_wr = 1'b0;
    end
    else
    begin
      if (prev_wr && prev_addr == a)
        ref_haz = ref_haz + 32'd1;
      if (we)
        ref_mem[a] = (ref_mem[a] & ~m) | (d & m);
      exp_q.push_back({~we, ref_mem[a]});
      prev_wr   = we;
      prev_addr = a;
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic idle();
    cyc_i   = 1'b0;
    stb_i   = 1'b0;
    we_i    = 1'b0;
    prev_wr = 1'b0;
    @(posedge clk_i);
    #2;
  endtask

  // Let all outstanding acks return, bounded
  task automatic wait_idle();
    int n;
    n = 0;
    idle();
    while (exp_q.size() != 0 && n < 20)
    begin
      idle();
      n++;
    end
    if (exp_q.size() != 0)
    begin
      errors = errors + 1;
      $display("ERROR at %0t: acks still outstanding after the drain timeout", $time);
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name);
    if (errors == err_start)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errors - err_start);
    err_start = errors;
  endtask

  initial
  begin
    void'($urandom(47));
    errors    = 0;
    checks    = 0;
    err_start = 0;
    ref_mask  = '1;
    ref_haz   = '0;
    prev_wr   = 1'b0;
    prev_addr = '0;
    rst_i     = 1'b1;
    cyc_i     = 1'b0;
    stb_i     = 1'b0;
    we_i      = 1'b0;
    adr_i     = '0;
    dat_i     = '0;
    sel_i     = '0;
    repeat (2) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    // Isolated full writes then reads, pattern spread over the whole address
    for (int a = 0; a < 64; a++)
    begin
      access(1'b1, 1'b0, 6'(a), 32'h9e3779b9 * 32'(a + 1), 4'hf);
      idle();
    end
    for (int a = 0; a < 64; a++)
    begin
      access(1'b0, 1'b0, 6'(a), '0, 4'hf);
      idle();
    end
    wait_idle();
    report_test("full_writes");

    // Mask register and partial selects
    access(1'b1, 1'b1, 6'd0, 32'hf0f0_3c3c, 4'hf);
    access(1'b0, 1'b1, 6'd0, '0, 4'hf);
    access(1'b1, 1'b0, 6'd5, $urandom, 4'b0101);
    idle();
    access(1'b0, 1'b0, 6'd5, '0, 4'hf);
    wait_idle();
    report_test("masked_write");

    // Back-to-back writes fold into one word
    access(1'b1, 1'b1, 6'd0, '1, 4'hf);
    access(1'b1, 1'b0, 6'd9, $urandom, 4'b0011);
    access(1'b1, 1'b0, 6'd9, $urandom, 4'b0110);
    idle();
    idle();
    access(1'b0, 1'b0, 6'd9, '0, 4'hf);
    wait_idle();
    report_test("write_merge");

    // Read right after a write to the same word
    access(1'b1, 1'b1, 6'd0, 32'h5a5a_a5a5, 4'hf);
    access(1'b1, 1'b0, 6'd12, $urandom, 4'b1011);
    access(1'b0, 1'b0, 6'd12, '0, 4'hf);
    access(1'b1, 1'b0, 6'd13, $urandom, 4'hf);
    access(1'b0, 1'b0, 6'd14, '0, 4'hf);
    wait_idle();
    report_test("read_after_write");

    // Hazard and non-hazard mix, then the counter
    access(1'b1, 1'b0, 6'd20, $urandom, 4'hf);
    access(1'b0, 1'b0, 6'd20, '0, 4'hf);
    idle();
    access(1'b1, 1'b0, 6'd21, $urandom, 4'hf);
    access(1'b0, 1'b0, 6'd22, '0, 4'hf);
    access(1'b1, 1'b0, 6'd22, $urandom, 4'b1100);
    access(1'b1, 1'b0, 6'd22, $urandom, 4'b0011);
    access(1'b0, 1'b0, 6'd23, '0, 4'hf);
    idle();
    access(1'b0, 1'b1, 6'd1, '0, 4'hf);
    // Counter ignores writes
    access(1'b1, 1'b1, 6'd1, 32'h0, 4'hf);
    access(1'b0, 1'b1, 6'd1, '0, 4'hf);
    wait_idle();
    report_test("hazard_count");

    // Dense random traffic over four words
    for (int i = 0; i < 400; i++)
    begin
      case ($urandom_range(0, 9))
        0: access(1'b1, 1'b1, 6'd0, $urandom, 4'hf);
        1: idle();
        default: access(1'($urandom), 1'b0, 6'($urandom_range(0, 3)), $urandom,
                        4'($urandom));
      endcase
    end
    access(1'b0, 1'b1, 6'd1, '0, 4'hf);
    wait_idle();
    report_test("random_traffic");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: src.f
hw/maskmem_pkg.sv
hw/ram_1r1w_sync.sv
hw/mask_write_mem.sv
hw/mem_ctrl_regs.sv
hw/wb_mem_port.sv
hw/mask_mem_top.sv
sim/tb_mask_mem.sv
